/* testbench/mem_input.txt */
# columns: kind (alu, load, store) addr data rd expected_regwdata, all hex except rd
# uart register is 3fffffc; for a uart load, data is the byte the host sends
alu 0 12345678 1 12345678
alu 0 deadbeef 2 deadbeef
store 40 cafef00d 0 0
load 40 0 3 cafef00d
load 40 0 4 cafef00d
store 40 0badc0de 0 0
load 40 0 5 0badc0de
load 80 0 6 0
store 44 11112222 0 0
load 44 0 7 11112222
load 3fffffc a5 8 a5
load 3fffffc 3c 9 3c
store 3fffffc 101 0 0
store 3fffffc 202 0 0
store 3fffffc 303 0 0
store 3fffffc 404 0 0
store 3fffffc 505 0 0
store 3fffffc 606 0 0
load 3fffffc 7e 10 7e
load 3fffffc 81 11 81
load 140 0 12 0
store 140 77778888 0 0
load 140 0 13 77778888
load 40 0 14 0badc0de
alu 0 0 15 0

/* tb.f */
rtl/mem_pkg.sv
rtl/uart_fifo.sv
rtl/backing_ram.sv
rtl/data_cache.sv
rtl/mem_stage.sv
rtl/mem_subsys_top.sv
testbench/mem_subsys_sva.sv
testbench/tb_mem_subsys.sv

/* testbench/tb_mem_subsys.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_mem_subsys;

    import mem_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] SEED         = 32'h35dc5d26;

    logic             clk;
    logic             rstn;
    logic             enable;
    mem_inst          inst;
    logic [31:0]      aluresult;
    logic [31:0]      result;
    logic [31:0]      rdata1;
    logic             fin;
    logic [31:0]      regwdata;
    logic [5:0]       rd;
    logic             regwrite;
    mem_inst          inst_out;
    logic             rx_push;
    logic [7:0]       rx_byte;
    logic             rx_full;
    logic             tx_pop;
    logic [7:0]       tx_byte;
    logic             tx_empty;

    // operations from the stimulus file
    string            kind_q [$];
    logic [31:0]      addr_q [$];
    logic [31:0]      data_q [$];
    logic [31:0]      exp_q [$];
    int               rd_q [$];

    // serial host queues
    logic [7:0]       rx_send_q [$];
    logic [7:0]       tx_exp_q [$];

    // reference memory and cache tag model
    logic [31:0]      ref_mem [int];
    logic [23:0]      line_tag [int];

    int               errors;
    int               tests_failed;
    int               rx_sent;
    int               rx_popped;
    bit               rx_pop_due;
    bit               ops_loaded;

    mem_subsys_top i_mem_subsys_top (
        .clk       (clk),
        .rstn      (rstn),
        .enable    (enable),
        .inst      (inst),
        .aluresult (aluresult),
        .result    (result),
        .rdata1    (rdata1),
        .fin       (fin),
        .regwdata  (regwdata),
        .rd        (rd),
        .regwrite  (regwrite),
        .inst_out  (inst_out),
        .rx_push   (rx_push),
        .rx_byte   (rx_byte),
        .rx_full   (rx_full),
        .tx_pop    (tx_pop),
        .tx_byte   (tx_byte),
        .tx_empty  (tx_empty)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit is_uart(input logic [31:0] a);
        return a[ADDR_BITS-1:0] == UART_ADDR;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          n;
        string       line;
        string       kind;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        int          r;
        fd = $fopen("testbench/mem_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file testbench/mem_input.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n < 3 || line.substr(0, 0) == "#") begin
                continue;
            end
            if ($sscanf(line, "%s %h %h %d %h", kind, a, d, r, e) != 5) begin
                continue;
            end
            kind_q.push_back(kind);
            addr_q.push_back(a);
            data_q.push_back(d);
            rd_q.push_back(r);
            exp_q.push_back(e);
            // host sends each uart load byte in file order
            if (kind == "load" && is_uart(a)) begin
                rx_send_q.push_back(d[7:0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_op(input int i);
        string       name;
        string       kind;
        logic [31:0] a;
        logic [31:0] d;
        int          stall;
        int          err0;
        int          key;
        int          idx;
        bit          exp_miss;
        bit          uart;
        logic [31:0] model_val;
        mem_inst     sent;
        kind     = kind_q[i];
        a        = addr_q[i];
        d        = data_q[i];
        uart     = is_uart(a);
        name     = $sformatf("op%0d_%s_%h", i, kind, a);
        err0     = errors;
        key      = int'(a[9:2]);
        idx      = int'(a[5:2]);
        exp_miss = 1'b0;

        sent          = '0;
        sent.rd       = rd_q[i][5:0];
        sent.regwrite = (kind != "store");
        sent.memread  = (kind == "load");
        sent.memwrite = (kind == "store");
        sent.memtoreg = (kind == "load");

        // cross-check the file against the reference model
        if (kind == "load" && uart) begin
            check({name, "_model"}, {24'b0, d[7:0]}, exp_q[i]);
        end else if (kind == "load") begin
            model_val = ref_mem.exists(key) ? ref_mem[key] : 32'h0;
            check({name, "_model"}, model_val, exp_q[i]);
            exp_miss = !(line_tag.exists(idx) && line_tag[idx] == a[25:2]);
            line_tag[idx] = a[25:2];
        end else if (kind == "store" && uart) begin
            tx_exp_q.push_back(d[7:0]);
        end else if (kind == "store") begin
            ref_mem[key] = d;
        end else begin
            check({name, "_model"}, d, exp_q[i]);
        end

        inst      = sent;
        aluresult = a;
        result    = (kind == "alu") ? d : 32'h0;
        rdata1    = d;
        enable    = 1'b1;
        @(posedge clk);
        @(negedge clk);
        enable = 1'b0;
        stall  = 0;
        while (!fin) begin
            stall++;
            @(negedge clk);
        end

        // the completed uart load pops its byte at the next rising edge
        if (kind == "load" && uart) begin
            rx_pop_due = 1'b1;
        end

        check({name, "_inst"}, {22'b0, sent}, {22'b0, inst_out});
        if (kind == "store") begin
            check({name, "_regwrite"}, 32'd0, {31'b0, regwrite});
        end else begin
            check({name, "_regwdata"}, exp_q[i], regwdata);
            check({name, "_rd"}, {26'b0, sent.rd}, {26'b0, rd});
            check({name, "_regwrite"}, 32'd1, {31'b0, regwrite});
        end
        // a miss stalls for the refill time and a hit never stalls
        if (!uart) begin
            check({name, "_stall"}, exp_miss ? REFILL_CYCLES : 0, stall);
        end

        if (errors != err0) begin
            tests_failed++;
        end
        $display("test %0d %s stall %0d %s", i, name, stall,
                 (errors == err0) ? "ok" : "error");
    endtask

    // bytes taken out of the receive FIFO by the stage
    always @(posedge clk) begin
        if (rx_pop_due) begin
            rx_popped++;
            rx_pop_due = 1'b0;
        end
    end

    // host side of the receive FIFO
    initial begin
        logic [31:0] seed;
        int          delay;
        seed = SEED;
        wait (ops_loaded && rstn);
        while (rx_send_q.size() > 0) begin
            seed  = lcg(seed);
            delay = (seed >> 16) % 12;
            repeat (delay) @(negedge clk);
            @(negedge clk);
            check("rx_full", {31'b0, (rx_sent - rx_popped) >= FIFO_DEPTH},
                  {31'b0, rx_full});
            while (rx_full) begin
                @(negedge clk);
            end
            rx_push = 1'b1;
            rx_byte = rx_send_q.pop_front();
            @(negedge clk);
            rx_push = 1'b0;
            rx_sent++;
        end
    end

    // transmit host pops slowly so the FIFO fills up
    initial begin
        logic [31:0] seed;
        int          delay;
        seed = lcg(SEED);
        forever begin
            @(negedge clk);
            if (tx_empty || !rstn) begin
                continue;
            end
            seed  = lcg(seed);
            delay = (seed >> 16) % 12;
            repeat (delay) @(negedge clk);
            if (tx_exp_q.size() == 0) begin
                $display("transmit FIFO delivered a byte that no store sent");
                errors++;
            end else begin
                check("tx_byte", {24'b0, tx_exp_q.pop_front()}, {24'b0, tx_byte});
            end
            tx_pop = 1'b1;
            @(negedge clk);
            tx_pop = 1'b0;
        end
    end

    // watchdog
    initial begin
        int limit;
        wait (ops_loaded);
        limit = kind_q.size() * (REFILL_CYCLES + 20) + 50;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        enable       = 1'b0;
        inst         = '0;
        aluresult    = '0;
        result       = '0;
        rdata1       = '0;
        rx_push      = 1'b0;
        rx_byte      = '0;
        tx_pop       = 1'b0;
        errors       = 0;
        tests_failed = 0;
        rx_sent      = 0;
        rx_popped    = 0;
        rx_pop_due   = 1'b0;
        ops_loaded   = 1'b0;

        read_stimulus();
        ops_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check("reset_fin", 32'd1, {31'b0, fin});
        check("reset_regwrite", 32'd0, {31'b0, regwrite});
        check("reset_tx_empty", 32'd1, {31'b0, tx_empty});

        for (int i = 0; i < kind_q.size(); i++) begin
            run_op(i);
        end

        // let the host drain the transmit side
        while (tx_exp_q.size() > 0 || rx_send_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        check("end_tx_empty", 32'd1, {31'b0, tx_empty});

        $display("%0d tests, %0d with errors, %0d errors in total",
                 kind_q.size(), tests_failed, errors);
        if (errors == 0 && kind_q.size() > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/mem_subsys_sva.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_subsys_sva (
    input wire clk,
    input wire rstn,
    input wire enable,
    input wire miss,
    input wire uart_rd_en,
    input wire uart_wr_en
);

    import mem_pkg::*;

    // no new op may enter EM while a refill is pending
    a_no_enable_in_miss: assert property (
        @(posedge clk) disable iff (!rstn)
        miss |-> !enable
    ) else $error("enable high while miss is high");

    a_uart_exclusive: assert property (
        @(posedge clk) disable iff (!rstn)
        !(uart_rd_en && uart_wr_en)
    ) else $error("uart read and write enables high together");

    // miss penalty bounded by the refill time
    a_miss_length: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(miss) |-> ##[1:REFILL_CYCLES] !miss
    ) else $error("miss lasted longer than the refill time");

endmodule

bind mem_stage mem_subsys_sva u_mem_subsys_sva (
    .clk        (clk),
    .rstn       (rstn),
    .enable     (enable),
    .miss       (miss),
    .uart_rd_en (uart_rd_en),
    .uart_wr_en (uart_wr_en)
);

`default_nettype wire

/* rtl/mem_subsys_top.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_subsys_top (
    input  wire                   clk,
    input  wire                   rstn,

    // pipeline side
    input  wire                   enable,
    input  wire mem_pkg::mem_inst inst,
    input  wire  [31:0]           aluresult,
    input  wire  [31:0]           result,
    input  wire  [31:0]           rdata1,
    output logic                  fin,
    output logic [31:0]           regwdata,
    output logic [5:0]            rd,
    output logic                  regwrite,
    output mem_pkg::mem_inst      inst_out,

    // serial host side
    input  wire                   rx_push,
    input  wire  [7:0]            rx_byte,
    output logic                  rx_full,
    input  wire                   tx_pop,
    output logic [7:0]            tx_byte,
    output logic                  tx_empty
);

    import mem_pkg::*;

    logic [31:0]              addr;
    logic [31:0]              wdata;
    logic                     read_enable;
    logic                     write_enable;
    logic [31:0]              rdata;
    logic                     miss;

    logic [RAM_ADDR_BITS-1:0] ram_addr;
    logic [31:0]              ram_wdata;
    logic                     ram_we;
    logic [31:0]              ram_rdata;

    logic [7:0]               uart_rx_data;
    logic [7:0]               uart_tx_data;
    logic                     uart_rd_en;
    logic                     uart_wr_en;
    logic                     rx_empty;
    logic                     tx_full;

    mem_stage u_mem_stage (
        .clk          (clk),
        .rstn         (rstn),
        .enable       (enable),
        .inst         (inst),
        .aluresult    (aluresult),
        .result       (result),
        .rdata1       (rdata1),
        .addr         (addr),
        .wdata        (wdata),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .rdata        (rdata),
        .miss         (miss),
        .uart_rx_data (uart_rx_data),
        .empty        (rx_empty),
        .full         (tx_full),
        .uart_rd_en   (uart_rd_en),
        .uart_wr_en   (uart_wr_en),
        .uart_tx_data (uart_tx_data),
        .inst_out     (inst_out),
        .regwdata     (regwdata),
        .rd           (rd),
        .regwrite     (regwrite),
        .fin          (fin)
    );

    data_cache u_data_cache (
        .clk          (clk),
        .rstn         (rstn),
        .addr         (addr),
        .wdata        (wdata),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .rdata        (rdata),
        .miss         (miss),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_we       (ram_we),
        .ram_rdata    (ram_rdata)
    );

    backing_ram u_backing_ram (
        .clk          (clk),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_we       (ram_we),
        .ram_rdata    (ram_rdata)
    );

    // host pushes, stage pops
    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk          (clk),
        .rstn         (rstn),
        .push         (rx_push),
        .push_data    (rx_byte),
        .pop          (uart_rd_en),
        .pop_data     (uart_rx_data),
        .empty        (rx_empty),
        .full         (rx_full)
    );

    // stage pushes, host pops
    uart_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk          (clk),
        .rstn         (rstn),
        .push         (uart_wr_en),
        .push_data    (uart_tx_data),
        .pop          (tx_pop),
        .pop_data     (tx_byte),
        .empty        (tx_empty),
        .full         (tx_full)
    );

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_stage (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  enable,
    input  wire mem_pkg::mem_inst inst,
    input  wire  [31:0]          aluresult,
    input  wire  [31:0]          result,
    input  wire  [31:0]          rdata1,

    // data cache
    output logic [31:0]          addr,
    output logic [31:0]          wdata,
    output logic                 read_enable,
    output logic                 write_enable,
    input  wire  [31:0]          rdata,
    input  wire                  miss,

    // uart fifos
    input  wire  [7:0]           uart_rx_data,
    input  wire                  empty,
    input  wire                  full,
    output logic                 uart_rd_en,
    output logic                 uart_wr_en,
    output logic [7:0]           uart_tx_data,

    // write-back
    output mem_pkg::mem_inst     inst_out,
    output logic [31:0]          regwdata,
    output logic [5:0]           rd,
    output logic                 regwrite,
    output logic                 fin
);

    import mem_pkg::*;

    mem_inst     inst_em;
    logic [31:0] aluresult_em;
    logic [31:0] result_em;
    logic [31:0] rdata1_em;
    logic        uart_now;
    logic        uart_em;
    logic        uart_done_q;
    logic [7:0]  rx_hold_q;
    logic [31:0] memrdata;

    // EX/MEM register, control part
    always_ff @(posedge clk) begin
        if (!rstn) begin
            inst_em <= '0;
        end else if (enable) begin
            inst_em <= inst;
        end
    end

    // EX/MEM register, payload part
    always_ff @(posedge clk) begin
        if (enable) begin
            aluresult_em <= aluresult;
            result_em    <= result;
            rdata1_em    <= rdata1;
        end
    end

    assign uart_now = (aluresult[ADDR_BITS-1:0] == UART_ADDR);
    assign uart_em  = (aluresult_em[ADDR_BITS-1:0] == UART_ADDR);

    // lookup uses the incoming op; during a miss the held op is shown
    assign addr         = miss ? aluresult_em : aluresult;
    assign wdata        = miss ? rdata1_em : rdata1;
    assign read_enable  = !miss && enable && inst.memread && !uart_now;
    assign write_enable = !miss && enable && inst.memwrite && !uart_now;

    // one fifo access per op, even if it stays in EM after completing
    always_ff @(posedge clk) begin
        if (!rstn) begin
            uart_done_q <= 1'b0;
        end else if (enable) begin
            uart_done_q <= 1'b0;
        end else if ((uart_rd_en && !empty) || (uart_wr_en && !full)) begin
            uart_done_q <= 1'b1;
        end
    end

    // popped byte kept so regwdata stays stable after the pop
    always_ff @(posedge clk) begin
        if (uart_rd_en && !empty) begin
            rx_hold_q <= uart_rx_data;
        end
    end

    assign uart_rd_en   = inst_em.memread && uart_em && !uart_done_q;
    assign uart_wr_en   = inst_em.memwrite && uart_em && !uart_done_q;
    assign uart_tx_data = rdata1_em[7:0];

    // write-back data select
    assign memrdata = !uart_em    ? rdata :
                      uart_done_q ? {24'b0, rx_hold_q} :
                                    {24'b0, uart_rx_data};
    assign regwdata = inst_em.memtoreg ? memrdata : result_em;

    assign inst_out = inst_em;
    assign rd       = inst_em.rd;
    assign regwrite = inst_em.regwrite;

    // stall on cache miss, empty rx or full tx
    assign fin = !miss && !(uart_rd_en && empty) && !(uart_wr_en && full);

endmodule

`default_nettype wire

/* rtl/data_cache.sv */
`default_nettype none
`timescale 1ns/10ps

module data_cache (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire  [31:0]                        addr,
    input  wire  [31:0]                        wdata,
    input  wire                                read_enable,
    input  wire                                write_enable,
    output logic [31:0]                        rdata,
    output logic                               miss,

    // backing ram
    output logic [mem_pkg::RAM_ADDR_BITS-1:0]  ram_addr,
    output logic [31:0]                        ram_wdata,
    output logic                               ram_we,
    input  wire  [31:0]                        ram_rdata
);

    import mem_pkg::*;

    logic [TAG_BITS-1:0]        tag_arr [CACHE_LINES];
    logic [31:0]                data_arr [CACHE_LINES];
    logic [CACHE_LINES-1:0]     valid_q;

    // last accepted read, looked up in the following cycle
    logic                       req_v_q;
    logic [31:0]                req_addr_q;
    logic [INDEX_BITS-1:0]      req_idx;
    logic [TAG_BITS-1:0]        req_tag;
    logic                       hit;

    // refill FSM, idle or refilling
    logic                       refill_q;
    logic [REFILL_CNT_BITS-1:0] cnt_q;
    logic                       fill;

    logic [INDEX_BITS-1:0]      wr_idx;
    logic [TAG_BITS-1:0]        wr_tag;
    logic                       wr_hit;

    assign req_idx = req_addr_q[INDEX_BITS+1:2];
    assign req_tag = req_addr_q[ADDR_BITS-1:INDEX_BITS+2];
    assign hit     = valid_q[req_idx] && (tag_arr[req_idx] == req_tag);

    assign wr_idx  = addr[INDEX_BITS+1:2];
    assign wr_tag  = addr[ADDR_BITS-1:INDEX_BITS+2];
    assign wr_hit  = valid_q[wr_idx] && (tag_arr[wr_idx] == wr_tag);

    // first miss cycle is the failed compare, the rest is refill
    assign miss  = refill_q || (req_v_q && !hit);
    assign fill  = refill_q && (cnt_q == '0);
    assign rdata = data_arr[req_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_v_q  <= 1'b0;
            refill_q <= 1'b0;
            cnt_q    <= '0;
            valid_q  <= '0;
        end else begin
            if (!miss) begin
                req_v_q <= read_enable;
            end
            if (req_v_q && !hit && !refill_q) begin
                refill_q <= 1'b1;
                cnt_q    <= REFILL_CNT_BITS'(REFILL_CYCLES - 2);
            end else if (fill) begin
                refill_q         <= 1'b0;
                valid_q[req_idx] <= 1'b1;
            end else if (refill_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_enable) begin
            req_addr_q <= addr;
        end
    end

    // line fill on refill end, update on write hit, no allocate
    always_ff @(posedge clk) begin
        if (fill) begin
            data_arr[req_idx] <= ram_rdata;
            tag_arr[req_idx]  <= req_tag;
        end else if (write_enable && wr_hit) begin
            data_arr[wr_idx] <= wdata;
        end
    end

    // write-through, store goes out in the same cycle
    assign ram_we    = write_enable;
    assign ram_wdata = wdata;
    assign ram_addr  = write_enable ? addr[RAM_ADDR_BITS+1:2] :
                                      req_addr_q[RAM_ADDR_BITS+1:2];

endmodule

`default_nettype wire

/* rtl/backing_ram.sv */
`default_nettype none
`timescale 1ns/10ps

module backing_ram (
    input  wire                                clk,
    input  wire  [mem_pkg::RAM_ADDR_BITS-1:0]  ram_addr,
    input  wire  [31:0]                        ram_wdata,
    input  wire                                ram_we,
    output logic [31:0]                        ram_rdata
);

    import mem_pkg::*;

    logic [31:0] mem_q [RAM_WORDS];

    // memory starts out all zero
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem_q[ram_addr] <= ram_wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        ram_rdata <= mem_q[ram_addr];
    end

endmodule

`default_nettype wire

/* rtl/uart_fifo.sv */
`default_nettype none
`timescale 1ns/10ps

module uart_fifo #(
    parameter int DEPTH = mem_pkg::FIFO_DEPTH
) (
    input  wire        clk,
    input  wire        rstn,
    input  wire        push,
    input  wire  [7:0] push_data,
    input  wire        pop,
    output logic [7:0] pop_data,
    output logic       empty,
    output logic       full
);

    logic [7:0]                   buf_q [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0]   count_q;
    logic                         do_push;
    logic                         do_pop;

    assign empty = (count_q == 0);
    assign full  = (count_q == DEPTH);

    // overflowing push and underflowing pop are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_q[wr_ptr_q] <= push_data;
        end
    end

    // show-ahead, head byte visible before the pop
    assign pop_data = buf_q[rd_ptr_q];

endmodule

`default_nettype wire

/* rtl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // control word carried from execute into the memory stage
    typedef struct packed {
        logic [5:0] rd;
        logic       regwrite;
        logic       memread;
        logic       memwrite;
        logic       memtoreg;
    } mem_inst;

    // only the low address bits take part in decoding
    localparam int ADDR_BITS = 26;
    localparam logic [ADDR_BITS-1:0] UART_ADDR = 26'h3fffffc;

    // direct-mapped cache, one word per line
    localparam int CACHE_LINES = 16;
    localparam int INDEX_BITS  = $clog2(CACHE_LINES);
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - 2;

    // backing store behind the cache
    localparam int RAM_WORDS     = 256;
    localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);

    // miss penalty in cycles, at least 2
    localparam int REFILL_CYCLES   = 4;
    localparam int REFILL_CNT_BITS = $clog2(REFILL_CYCLES);

    // uart byte fifos
    localparam int FIFO_DEPTH = 4;

endpackage

`default_nettype wire
